// File: hw/pad_pkg.sv
// Pad count, configuration width, mode codes and the pad index map.
// Every pad mux block and the checker import this package.
`default_nettype none

package pad_pkg;

   localparam int N_PADS    = 32;
   localparam int PAD_CFG_W = 6;

   typedef logic [1:0]           pad_mode_t;
   typedef logic [N_PADS-1:0]    pad_vec_t;
   typedef logic [PAD_CFG_W-1:0] pad_cfg_t;
   typedef logic [3:0]           qspi_t;
   typedef logic [7:0]           cam_data_t;
   typedef logic [3:0]           timer_t;

   // Pad mode codes
   localparam pad_mode_t MODE_FUNC = 2'd0;
   localparam pad_mode_t MODE_GPIO = 2'd1;
   localparam pad_mode_t MODE_ALT2 = 2'd2;
   localparam pad_mode_t MODE_ALT3 = 2'd3;

   ////////////////////////////////////////////////////////////////////////////
   // Pad map, dense, GPIO index equals pad index
   ////////////////////////////////////////////////////////////////////////////

   // SPI master
   localparam int PAD_SPIM_SDIO0 = 0;
   localparam int PAD_SPIM_SDIO1 = 1;
   localparam int PAD_SPIM_SDIO2 = 2;
   localparam int PAD_SPIM_SDIO3 = 3;
   localparam int PAD_SPIM_CSN0  = 4;
   localparam int PAD_SPIM_CSN1  = 5;
   localparam int PAD_SPIM_SCK   = 6;

   // UART
   localparam int PAD_UART_RX    = 7;
   localparam int PAD_UART_TX    = 8;

   // Camera, data bits 0..7 on consecutive pads
   localparam int PAD_CAM_PCLK   = 9;
   localparam int PAD_CAM_HSYNC  = 10;
   localparam int PAD_CAM_DATA0  = 11;
   localparam int PAD_CAM_VSYNC  = 19;

   // SDIO, data bits 0..3 on consecutive pads
   localparam int PAD_SDIO_CLK   = 20;
   localparam int PAD_SDIO_CMD   = 21;
   localparam int PAD_SDIO_DATA0 = 22;

   // I2C bus 0 and I2S slave
   localparam int PAD_I2C0_SDA   = 26;
   localparam int PAD_I2C0_SCL   = 27;
   localparam int PAD_I2S0_SCK   = 28;
   localparam int PAD_I2S0_WS    = 29;
   localparam int PAD_I2S0_SDI   = 30;
   localparam int PAD_I2S1_SDI   = 31;

endpackage

`default_nettype wire

// File: hw/pad_out_mux.sv
// Output value and output enable for every pad, chosen by the pad mode.
// Function and alternate 2 sources are laid out by the pad map first.
`timescale 1ns/10ps
`default_nettype none

module pad_out_mux import pad_pkg::*; (
   input  pad_mode_t  pad_mux_i [N_PADS],
   input  logic       spi_sck_i,
   input  logic [1:0] spi_csn_i,
   input  qspi_t      spi_sdo_i,
   input  qspi_t      spi_oen_i,
   input  logic       uart_tx_i,
   input  logic       sdio_clk_i,
   input  logic       sdio_cmd_i,
   input  logic       sdio_cmd_oen_i,
   input  qspi_t      sdio_data_i,
   input  qspi_t      sdio_data_oen_i,
   input  logic [1:0] i2c_sda_out_i,
   input  logic [1:0] i2c_sda_oe_i,
   input  logic [1:0] i2c_scl_out_i,
   input  logic [1:0] i2c_scl_oe_i,
   input  logic       i2s_sck_i,
   input  logic       i2s_sck_oe_i,
   input  logic       i2s_ws_i,
   input  logic       i2s_ws_oe_i,
   input  timer_t     timer1_i,
   input  timer_t     timer2_i,
   input  timer_t     timer3_i,
   input  pad_vec_t   gpio_out_i,
   input  pad_vec_t   gpio_dir_i,
   output pad_vec_t   pad_out_o,
   output pad_vec_t   pad_oe_o
);

   pad_vec_t func_out;
   pad_vec_t func_oe;
   pad_vec_t alt2_out;
   pad_vec_t alt2_oe;

   ////////////////////////////////////////////////////////////////////////////
   // Function mode sources
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      // Input-only pads stay undriven
      func_out = '0;
      func_oe  = '0;
      for (int i = 0; i < 4; i++) begin
         func_out[PAD_SPIM_SDIO0 + i] = spi_sdo_i[i];
         func_oe[PAD_SPIM_SDIO0 + i]  = ~spi_oen_i[i];
         func_out[PAD_SDIO_DATA0 + i] = sdio_data_i[i];
         func_oe[PAD_SDIO_DATA0 + i]  = ~sdio_data_oen_i[i];
      end
      func_out[PAD_SPIM_CSN0] = spi_csn_i[0];
      func_oe[PAD_SPIM_CSN0]  = 1'b1;
      func_out[PAD_SPIM_CSN1] = spi_csn_i[1];
      func_oe[PAD_SPIM_CSN1]  = 1'b1;
      func_out[PAD_SPIM_SCK]  = spi_sck_i;
      func_oe[PAD_SPIM_SCK]   = 1'b1;
      func_out[PAD_UART_TX]   = uart_tx_i;
      func_oe[PAD_UART_TX]    = 1'b1;
      func_out[PAD_SDIO_CLK]  = sdio_clk_i;
      func_oe[PAD_SDIO_CLK]   = 1'b1;
      func_out[PAD_SDIO_CMD]  = sdio_cmd_i;
      func_oe[PAD_SDIO_CMD]   = ~sdio_cmd_oen_i;
      func_out[PAD_I2C0_SDA]  = i2c_sda_out_i[0];
      func_oe[PAD_I2C0_SDA]   = i2c_sda_oe_i[0];
      func_out[PAD_I2C0_SCL]  = i2c_scl_out_i[0];
      func_oe[PAD_I2C0_SCL]   = i2c_scl_oe_i[0];
      func_out[PAD_I2S0_SCK]  = i2s_sck_i;
      func_oe[PAD_I2S0_SCK]   = i2s_sck_oe_i;
      func_out[PAD_I2S0_WS]   = i2s_ws_i;
      func_oe[PAD_I2S0_WS]    = i2s_ws_oe_i;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Alternate 2 sources, I2C bus 1 and timers
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      alt2_out = '0;
      alt2_oe  = '0;
      // Three candidate pad pairs for I2C1
      alt2_out[PAD_SPIM_SDIO2]     = i2c_sda_out_i[1];
      alt2_oe[PAD_SPIM_SDIO2]      = i2c_sda_oe_i[1];
      alt2_out[PAD_UART_RX]        = i2c_sda_out_i[1];
      alt2_oe[PAD_UART_RX]         = i2c_sda_oe_i[1];
      alt2_out[PAD_SDIO_DATA0 + 2] = i2c_sda_out_i[1];
      alt2_oe[PAD_SDIO_DATA0 + 2]  = i2c_sda_oe_i[1];
      alt2_out[PAD_SPIM_SDIO3]     = i2c_scl_out_i[1];
      alt2_oe[PAD_SPIM_SDIO3]      = i2c_scl_oe_i[1];
      alt2_out[PAD_UART_TX]        = i2c_scl_out_i[1];
      alt2_oe[PAD_UART_TX]         = i2c_scl_oe_i[1];
      alt2_out[PAD_SDIO_DATA0 + 3] = i2c_scl_out_i[1];
      alt2_oe[PAD_SDIO_DATA0 + 3]  = i2c_scl_oe_i[1];
      // Timers on the 11 camera pads, timer3 bit 3 has no pad
      alt2_out[PAD_CAM_PCLK +: 11] = {timer3_i[2:0], timer2_i, timer1_i};
      alt2_oe[PAD_CAM_PCLK +: 11]  = '1;
   end

   // Per pad mode select
   always_comb begin
      for (int p = 0; p < N_PADS; p++) begin
         case (pad_mux_i[p])
            MODE_FUNC: begin
               pad_out_o[p] = func_out[p];
               pad_oe_o[p]  = func_oe[p];
            end
            MODE_GPIO: begin
               pad_out_o[p] = gpio_out_i[p];
               pad_oe_o[p]  = gpio_dir_i[p];
            end
            MODE_ALT2: begin
               pad_out_o[p] = alt2_out[p];
               pad_oe_o[p]  = alt2_oe[p];
            end
            // Alternate 3 parks the pad
            default: begin
               pad_out_o[p] = 1'b0;
               pad_oe_o[p]  = 1'b0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hw/pad_in_route.sv
// Routes pad inputs to the peripherals and to the GPIO block.
// A peripheral sees its pad only in function mode, else its idle level.
`timescale 1ns/10ps
`default_nettype none

module pad_in_route import pad_pkg::*; (
   input  pad_mode_t  pad_mux_i [N_PADS],
   input  pad_vec_t   pad_in_i,
   output qspi_t      spi_sdi_o,
   output qspi_t      sdio_data_o,
   output logic       sdio_cmd_o,
   output logic       uart_rx_o,
   output logic       cam_pclk_o,
   output logic       cam_hsync_o,
   output logic       cam_vsync_o,
   output cam_data_t  cam_data_o,
   output logic [1:0] i2c_sda_in_o,
   output logic [1:0] i2c_scl_in_o,
   output logic       i2s_sck_o,
   output logic       i2s_ws_o,
   output logic       i2s_sd0_o,
   output logic       i2s_sd1_o,
   output pad_vec_t   gpio_in_o
);

   pad_vec_t func_sel;
   pad_vec_t gpio_sel;
   pad_vec_t alt2_sel;
   pad_vec_t func_in;

   // Mode decode per pad
   always_comb begin
      for (int p = 0; p < N_PADS; p++) begin
         func_sel[p] = (pad_mux_i[p] == MODE_FUNC);
         gpio_sel[p] = (pad_mux_i[p] == MODE_GPIO);
         alt2_sel[p] = (pad_mux_i[p] == MODE_ALT2);
      end
   end

   // Inputs that idle low
   assign func_in = pad_in_i & func_sel;

   assign spi_sdi_o = {func_in[PAD_SPIM_SDIO3], func_in[PAD_SPIM_SDIO2],
                       func_in[PAD_SPIM_SDIO1], func_in[PAD_SPIM_SDIO0]};

   assign sdio_cmd_o  = func_in[PAD_SDIO_CMD];
   assign sdio_data_o = func_in[PAD_SDIO_DATA0 +: 4];
   assign cam_pclk_o  = func_in[PAD_CAM_PCLK];
   assign cam_hsync_o = func_in[PAD_CAM_HSYNC];
   assign cam_vsync_o = func_in[PAD_CAM_VSYNC];
   assign cam_data_o  = func_in[PAD_CAM_DATA0 +: 8];
   assign i2s_sck_o   = func_in[PAD_I2S0_SCK];
   assign i2s_ws_o    = func_in[PAD_I2S0_WS];
   assign i2s_sd0_o   = func_in[PAD_I2S0_SDI];
   assign i2s_sd1_o   = func_in[PAD_I2S1_SDI];

   // UART and I2C0 idle high
   assign uart_rx_o       = func_sel[PAD_UART_RX]  ? pad_in_i[PAD_UART_RX]  : 1'b1;
   assign i2c_sda_in_o[0] = func_sel[PAD_I2C0_SDA] ? pad_in_i[PAD_I2C0_SDA] : 1'b1;
   assign i2c_scl_in_o[0] = func_sel[PAD_I2C0_SCL] ? pad_in_i[PAD_I2C0_SCL] : 1'b1;

   // I2C1 takes the lowest alternate 2 pad, bus idles high
   always_comb begin
      if (alt2_sel[PAD_SPIM_SDIO2])
         i2c_sda_in_o[1] = pad_in_i[PAD_SPIM_SDIO2];
      else if (alt2_sel[PAD_UART_RX])
         i2c_sda_in_o[1] = pad_in_i[PAD_UART_RX];
      else if (alt2_sel[PAD_SDIO_DATA0 + 2])
         i2c_sda_in_o[1] = pad_in_i[PAD_SDIO_DATA0 + 2];
      else
         i2c_sda_in_o[1] = 1'b1;

      if (alt2_sel[PAD_SPIM_SDIO3])
         i2c_scl_in_o[1] = pad_in_i[PAD_SPIM_SDIO3];
      else if (alt2_sel[PAD_UART_TX])
         i2c_scl_in_o[1] = pad_in_i[PAD_UART_TX];
      else if (alt2_sel[PAD_SDIO_DATA0 + 3])
         i2c_scl_in_o[1] = pad_in_i[PAD_SDIO_DATA0 + 3];
      else
         i2c_scl_in_o[1] = 1'b1;
   end

   assign gpio_in_o = pad_in_i & gpio_sel;

endmodule

`default_nettype wire

// File: hw/pad_cfg_sel.sv
// Pad configuration select, GPIO owned pads take the GPIO configuration.
`timescale 1ns/10ps
`default_nettype none

module pad_cfg_sel import pad_pkg::*; (
   input  pad_mode_t pad_mux_i  [N_PADS],
   input  pad_cfg_t  pad_cfg_i  [N_PADS],
   input  pad_cfg_t  gpio_cfg_i [N_PADS],
   output pad_cfg_t  pad_cfg_o  [N_PADS]
);

   always_comb begin
      for (int p = 0; p < N_PADS; p++) begin
         if (pad_mux_i[p] == MODE_GPIO) begin
            pad_cfg_o[p] = gpio_cfg_i[p];
         end else begin
            // Function and alternate modes keep the default
            pad_cfg_o[p] = pad_cfg_i[p];
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/pad_control.sv
// Pad mux top level between the peripherals and the pad frame.
// Pure combinational, the pad mode array comes from the pad control registers.
`timescale 1ns/10ps
`default_nettype none

module pad_control import pad_pkg::*; (
   // Mode and configuration
   input  pad_mode_t  pad_mux_i  [N_PADS],
   input  pad_cfg_t   pad_cfg_i  [N_PADS],
   input  pad_cfg_t   gpio_cfg_i [N_PADS],
   output pad_cfg_t   pad_cfg_o  [N_PADS],
   // SPI master
   input  logic       spi_sck_i,
   input  logic [1:0] spi_csn_i,
   input  qspi_t      spi_sdo_i,
   input  qspi_t      spi_oen_i,
   output qspi_t      spi_sdi_o,
   // UART
   input  logic       uart_tx_i,
   output logic       uart_rx_o,
   // SDIO
   input  logic       sdio_clk_i,
   input  logic       sdio_cmd_i,
   input  logic       sdio_cmd_oen_i,
   output logic       sdio_cmd_o,
   input  qspi_t      sdio_data_i,
   input  qspi_t      sdio_data_oen_i,
   output qspi_t      sdio_data_o,
   // Camera
   output logic       cam_pclk_o,
   output logic       cam_hsync_o,
   output logic       cam_vsync_o,
   output cam_data_t  cam_data_o,
   // I2C buses 0 and 1
   input  logic [1:0] i2c_sda_out_i,
   input  logic [1:0] i2c_sda_oe_i,
   output logic [1:0] i2c_sda_in_o,
   input  logic [1:0] i2c_scl_out_i,
   input  logic [1:0] i2c_scl_oe_i,
   output logic [1:0] i2c_scl_in_o,
   // I2S slave
   input  logic       i2s_sck_i,
   input  logic       i2s_sck_oe_i,
   input  logic       i2s_ws_i,
   input  logic       i2s_ws_oe_i,
   output logic       i2s_sck_o,
   output logic       i2s_ws_o,
   output logic       i2s_sd0_o,
   output logic       i2s_sd1_o,
   // Timers
   input  timer_t     timer1_i,
   input  timer_t     timer2_i,
   input  timer_t     timer3_i,
   // GPIO
   input  pad_vec_t   gpio_out_i,
   input  pad_vec_t   gpio_dir_i,
   output pad_vec_t   gpio_in_o,
   // Pad frame
   output pad_vec_t   pad_out_o,
   output pad_vec_t   pad_oe_o,
   input  pad_vec_t   pad_in_i
);

   pad_out_mux u_out_mux (.*);

   pad_in_route u_in_route (.*);

   pad_cfg_sel u_cfg_sel (
      .pad_mux_i  (pad_mux_i),
      .pad_cfg_i  (pad_cfg_i),
      .gpio_cfg_i (gpio_cfg_i),
      .pad_cfg_o  (pad_cfg_o)
   );

endmodule

`default_nettype wire

// File: tb/pad_checker.sv
// Reference model of the pad mux rules, compared against the DUT on each rising edge.
// Source bit layout of src_i follows the stimulus vector of the testbench.
`timescale 1ns/10ps
`default_nettype none

module pad_checker import pad_pkg::*; (
   input  logic        clk_i,
   input  logic        check_en_i,
   input  logic [63:0] name_i,
   input  pad_mode_t   mode_i     [N_PADS],
   input  logic [63:0] src_i,
   input  pad_vec_t    pad_in_i,
   input  pad_vec_t    gpio_out_i,
   input  pad_vec_t    gpio_dir_i,
   input  pad_cfg_t    pad_cfg_i  [N_PADS],
   input  pad_cfg_t    gpio_cfg_i [N_PADS],
   input  pad_cfg_t    dut_cfg_i  [N_PADS],
   input  pad_vec_t    dut_out_i,
   input  pad_vec_t    dut_oe_i,
   input  pad_vec_t    dut_gpio_in_i,
   input  logic [28:0] dut_periph_i
);

   int          err_count = 0;
   int          check_count = 0;
   pad_vec_t    exp_out;
   pad_vec_t    exp_oe;
   pad_vec_t    exp_gpio_in;
   pad_vec_t    fsel;
   pad_vec_t    a2sel;
   pad_vec_t    fin;
   pad_cfg_t    exp_cfg;
   logic [28:0] exp_per;
   logic [1:0]  drv;

   ////////////////////////////////////////////////////////////////////////////
   // Expected {oe, out} of one pad per mode
   ////////////////////////////////////////////////////////////////////////////
   function automatic logic [1:0] func_drive(input int p, input logic [63:0] s);
      case (p)
         0, 1, 2, 3:     return {~s[p+7], s[p+3]};
         4, 5:           return {1'b1, s[p-3]};
         6:              return {1'b1, s[0]};
         8:              return {1'b1, s[11]};
         20:             return {1'b1, s[12]};
         21:             return {~s[14], s[13]};
         22, 23, 24, 25: return {~s[p-3], s[p-7]};
         26:             return {s[25], s[23]};
         27:             return {s[29], s[27]};
         28:             return {s[32], s[31]};
         29:             return {s[34], s[33]};
         default:        return 2'b00;
      endcase
   endfunction

   function automatic logic [1:0] alt2_drive(input int p, input logic [63:0] s);
      logic [10:0] tmr;
      // timer1 on pads 9..12, timer2 on 13..16, timer3 low bits on 17..19
      tmr = {s[45:43], s[42:39], s[38:35]};
      if (p >= 9 && p <= 19)
         return {1'b1, tmr[p-9]};
      case (p)
         2, 7, 24: return {s[26], s[24]};
         3, 8, 25: return {s[30], s[28]};
         default:  return 2'b00;
      endcase
   endfunction

   task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
      check_count++;
      if (exp !== act) begin
         err_count++;
         $display("[FAIL] %s %s: expected %h, actual %h", name_i, what, exp, act);
      end
   endtask

   always @(posedge clk_i) begin
      if (check_en_i) begin
         for (int p = 0; p < N_PADS; p++) begin
            case (mode_i[p])
               MODE_FUNC: drv = func_drive(p, src_i);
               MODE_GPIO: drv = {gpio_dir_i[p], gpio_out_i[p]};
               MODE_ALT2: drv = alt2_drive(p, src_i);
               default:   drv = 2'b00;
            endcase
            exp_out[p]     = drv[0];
            exp_oe[p]      = drv[1];
            fsel[p]        = (mode_i[p] == MODE_FUNC);
            a2sel[p]       = (mode_i[p] == MODE_ALT2);
            exp_gpio_in[p] = (mode_i[p] == MODE_GPIO) & pad_in_i[p];
            exp_cfg        = (mode_i[p] == MODE_GPIO) ? gpio_cfg_i[p] : pad_cfg_i[p];
            compare($sformatf("pad_cfg_o[%0d]", p), 32'(exp_cfg), 32'(dut_cfg_i[p]));
         end
         fin = pad_in_i & fsel;
         // Idle low unless noted
         exp_per[3:0]   = fin[3:0];
         exp_per[7:4]   = fin[25:22];
         exp_per[8]     = fin[21];
         exp_per[9]     = fsel[7] ? pad_in_i[7] : 1'b1;
         exp_per[10]    = fin[9];
         exp_per[11]    = fin[10];
         exp_per[12]    = fin[19];
         exp_per[20:13] = fin[18:11];
         exp_per[21]    = fsel[26] ? pad_in_i[26] : 1'b1;
         exp_per[22]    = a2sel[2] ? pad_in_i[2] :
                          a2sel[7] ? pad_in_i[7] :
                          a2sel[24] ? pad_in_i[24] : 1'b1;
         exp_per[23]    = fsel[27] ? pad_in_i[27] : 1'b1;
         exp_per[24]    = a2sel[3] ? pad_in_i[3] :
                          a2sel[8] ? pad_in_i[8] :
                          a2sel[25] ? pad_in_i[25] : 1'b1;
         exp_per[28:25] = fin[31:28];
         compare("pad_out_o", exp_out, dut_out_i);
         compare("pad_oe_o", exp_oe, dut_oe_i);
         compare("gpio_in_o", exp_gpio_in, dut_gpio_in_i);
         compare("peripheral inputs", 32'(exp_per), 32'(dut_periph_i));
      end
   end

endmodule

`default_nettype wire

// File: tb/tb_pad_control.sv
// Testbench for the pad mux top level.
// Runs a table of mode patterns with random data on every DUT input.
// The checker instance holds the reference model and the error count.
`timescale 1ns/10ps
`default_nettype none

module tb_pad_control import pad_pkg::*;;

   localparam int N_ROWS     = 6;
   localparam int REPEATS    = 16;
   localparam int TIMEOUT    = 8 + N_ROWS * REPEATS + 20;
   localparam int KIND_MIXED = 4;

   // Row kind 0..3 is a uniform mode code
   // KIND_MIXED draws per pad modes
   logic [63:0] row_name [N_ROWS] = '{"all_gpio", "all_func", "all_alt2",
                                      "all_alt3", "mixed_01", "mixed_02"};
   int          row_kind [N_ROWS] = '{1, 0, 2, 3, KIND_MIXED, KIND_MIXED};

   logic        clk_i;
   logic        rst_i;
   logic        check_en;
   logic [63:0] cur_name;
   logic [31:0] seed = 32'h6526_0f9d;
   int          cycles = 0;
   pad_mode_t   mode     [N_PADS];
   pad_cfg_t    pad_cfg  [N_PADS];
   pad_cfg_t    gpio_cfg [N_PADS];
   pad_cfg_t    cfg_out  [N_PADS];
   logic [63:0] src;
   pad_vec_t    pad_in;
   pad_vec_t    gpio_out;
   pad_vec_t    gpio_dir;
   pad_vec_t    pad_out;
   pad_vec_t    pad_oe;
   pad_vec_t    gpio_in;
   logic [28:0] per_in;

   pad_control dut (
      .pad_mux_i       (mode),
      .pad_cfg_i       (pad_cfg),
      .gpio_cfg_i      (gpio_cfg),
      .pad_cfg_o       (cfg_out),
      .spi_sck_i       (src[0]),
      .spi_csn_i       (src[2:1]),
      .spi_sdo_i       (src[6:3]),
      .spi_oen_i       (src[10:7]),
      .spi_sdi_o       (per_in[3:0]),
      .uart_tx_i       (src[11]),
      .uart_rx_o       (per_in[9]),
      .sdio_clk_i      (src[12]),
      .sdio_cmd_i      (src[13]),
      .sdio_cmd_oen_i  (src[14]),
      .sdio_cmd_o      (per_in[8]),
      .sdio_data_i     (src[18:15]),
      .sdio_data_oen_i (src[22:19]),
      .sdio_data_o     (per_in[7:4]),
      .cam_pclk_o      (per_in[10]),
      .cam_hsync_o     (per_in[11]),
      .cam_vsync_o     (per_in[12]),
      .cam_data_o      (per_in[20:13]),
      .i2c_sda_out_i   (src[24:23]),
      .i2c_sda_oe_i    (src[26:25]),
      .i2c_sda_in_o    ({per_in[22], per_in[21]}),
      .i2c_scl_out_i   (src[28:27]),
      .i2c_scl_oe_i    (src[30:29]),
      .i2c_scl_in_o    ({per_in[24], per_in[23]}),
      .i2s_sck_i       (src[31]),
      .i2s_sck_oe_i    (src[32]),
      .i2s_ws_i        (src[33]),
      .i2s_ws_oe_i     (src[34]),
      .i2s_sck_o       (per_in[25]),
      .i2s_ws_o        (per_in[26]),
      .i2s_sd0_o       (per_in[27]),
      .i2s_sd1_o       (per_in[28]),
      .timer1_i        (src[38:35]),
      .timer2_i        (src[42:39]),
      .timer3_i        (src[46:43]),
      .gpio_out_i      (gpio_out),
      .gpio_dir_i      (gpio_dir),
      .gpio_in_o       (gpio_in),
      .pad_out_o       (pad_out),
      .pad_oe_o        (pad_oe),
      .pad_in_i        (pad_in)
   );

   pad_checker chk (
      .clk_i         (clk_i),
      .check_en_i    (check_en),
      .name_i        (cur_name),
      .mode_i        (mode),
      .src_i         (src),
      .pad_in_i      (pad_in),
      .gpio_out_i    (gpio_out),
      .gpio_dir_i    (gpio_dir),
      .pad_cfg_i     (pad_cfg),
      .gpio_cfg_i    (gpio_cfg),
      .dut_cfg_i     (cfg_out),
      .dut_out_i     (pad_out),
      .dut_oe_i      (pad_oe),
      .dut_gpio_in_i (gpio_in),
      .dut_periph_i  (per_in)
   );

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   task automatic apply_row(input int r);
      logic [31:0] word;
      src      = {next_rand(), next_rand()};
      pad_in   = next_rand();
      gpio_out = next_rand();
      gpio_dir = next_rand();
      cur_name = row_name[r];
      for (int p = 0; p < N_PADS; p++) begin
         word        = next_rand();
         pad_cfg[p]  = word[21:16];
         gpio_cfg[p] = word[27:22];
         if (row_kind[r] == KIND_MIXED)
            mode[p] = word[31:30];
         else
            mode[p] = pad_mode_t'(row_kind[r]);
      end
   endtask

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   // Reset held for 8 cycles
   initial begin
      rst_i = 1'b1;
      repeat (8) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
   end

   // Run limit
   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
         $display(">>> FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      check_en = 1'b0;
      cur_name = '0;
      src      = '0;
      pad_in   = '0;
      gpio_out = '0;
      gpio_dir = '0;
      for (int p = 0; p < N_PADS; p++) begin
         mode[p]     = MODE_FUNC;
         pad_cfg[p]  = '0;
         gpio_cfg[p] = '0;
      end
      wait (rst_i === 1'b0);
      for (int r = 0; r < N_ROWS; r++) begin
         for (int k = 0; k < REPEATS; k++) begin
            @(negedge clk_i);
            apply_row(r);
            check_en = 1'b1;
         end
      end
      // Let the last row be sampled
      @(negedge clk_i);
      check_en = 1'b0;
      $display("Checks: %0d, errors: %0d", chk.check_count, chk.err_count);
      if (chk.err_count == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: pad_mux.f
hw/pad_pkg.sv
hw/pad_out_mux.sv
hw/pad_in_route.sv
hw/pad_cfg_sel.sv
hw/pad_control.sv
tb/pad_checker.sv
tb/tb_pad_control.sv

// File: run_sim.sh
#!/bin/sh
# Builds the pad mux testbench with Verilator and runs it once.
# The run counts as passed only if the pass line shows up in the output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module tb_pad_control \
   -f pad_mux.f -o tb_pad_control \
   && ./obj_dir/tb_pad_control | tee /dev/stderr | grep -qx ">>> PASS" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
